//--- rom_loader_pkg.sv
///////////////////////////////
// Shared widths, load addresses and header layout for the ROM loader.
// Modules import this inside their body and use scoped names in headers.
///////////////////////////////
package rom_loader_pkg;

	localparam int MEM_ADDR_W = 22;
	localparam int BYTE_W = 8;
	localparam int FLAGS_W = 32;
	localparam int HDR_BYTES = 16;

	// Load addresses in the external memory
	localparam logic [MEM_ADDR_W-1:0] PRG_BASE = 22'h000000;
	localparam logic [MEM_ADDR_W-1:0] CHR_BASE = 22'h200000;
	localparam logic [MEM_ADDR_W-1:0] FDS_BASE = 22'h010000;

	localparam logic [BYTE_W-1:0] FT_BIOS = 8'd2;	// Host file index for a BIOS image
	localparam logic [BYTE_W-1:0] FT_FDS = 8'd3;

	localparam int PRG_PAGE_LOG2 = 14;	// 16 KiB pages
	localparam int CHR_PAGE_LOG2 = 13;	// 8 KiB pages

	// Magic words, first received byte in the low bits
	localparam logic [31:0] MAGIC_NES = 32'h1A53_454E;
	localparam logic [31:0] MAGIC_FDS = 32'h1A53_4446;

	// Bit positions inside the mapper-flags word
	localparam int FLG_MAPPER_LSB = 0;
	localparam int FLG_PRG_LSB = 8;
	localparam int FLG_CHR_LSB = 11;
	localparam int FLG_MIRROR = 14;
	localparam int FLG_CHR_RAM = 15;
	localparam int FLG_FOUR_SCR = 16;
	localparam int FLG_EXT_LSB = 17;
	localparam int SIZE_CODE_W = 3;

	// Header as captured (bytes) and as decoded (fields)
	// Packed order puts byte 0 in the low bits, so fields run from the tail down
	typedef union packed {
		logic [HDR_BYTES-1:0][BYTE_W-1:0] bytes;
		struct packed {
			logic [6:0][BYTE_W-1:0] tail;	// Bytes 9..15
			logic [BYTE_W-1:0] ext8;
			logic [BYTE_W-1:0] flags7;
			logic [BYTE_W-1:0] flags6;
			logic [BYTE_W-1:0] chr_pages;
			logic [BYTE_W-1:0] prg_pages;
			logic [3:0][BYTE_W-1:0] magic;
		} fields;
	} ines_header_u;

	typedef enum logic [1:0] {
		KIND_INES,
		KIND_FDS,
		KIND_BIOS,
		KIND_BAD
	} hdr_kind_e;

endpackage

//--- ines_header_decode.sv
///////////////////////////////
// Classifies the captured image header and builds the mapper-flags word.
// Purely combinational, read by the sequencer and the reset controller.
///////////////////////////////
`timescale 1ns/10ps

module ines_header_decode (
	input rom_loader_pkg::ines_header_u header,
	input logic [rom_loader_pkg::BYTE_W-1:0] filetype,
	input logic invert_mirroring,
	output rom_loader_pkg::hdr_kind_e kind,
	output logic [rom_loader_pkg::BYTE_W-1:0] prg_pages,
	output logic [rom_loader_pkg::BYTE_W-1:0] chr_pages,
	output logic [rom_loader_pkg::FLAGS_W-1:0] flags_word
);
	import rom_loader_pkg::*;

	logic is_nes20;
	logic is_dirty;
	logic [BYTE_W-1:0] mapper_num;
	logic [BYTE_W-1:0] ext_mapper;
	logic [SIZE_CODE_W-1:0] prg_code;
	logic [SIZE_CODE_W-1:0] chr_code;

	// Smallest k with pages <= 2^k, capped at 7
	function automatic logic [SIZE_CODE_W-1:0] size_code(input logic [BYTE_W-1:0] pages);
		logic [SIZE_CODE_W-1:0] code;
		code = 3'd7;
		for (int k = 6; k >= 0; k--) begin
			if (pages <= (8'd1 << k))
				code = k[SIZE_CODE_W-1:0];
		end
		return code;
	endfunction

	assign prg_pages = header.fields.prg_pages;
	assign chr_pages = header.fields.chr_pages;

	assign is_nes20 = (header.fields.flags7[3:2] == 2'b10);

	// Old dumps often carry junk in bytes 8..15, which spoils flags7 as well
	assign is_dirty = !is_nes20 && ({header.fields.ext8, header.fields.tail} != '0);

	assign mapper_num = {is_dirty ? 4'h0 : header.fields.flags7[7:4],
		header.fields.flags6[7:4]};
	assign ext_mapper = is_nes20 ? header.fields.ext8 : '0;

	assign prg_code = size_code(prg_pages);
	assign chr_code = size_code(chr_pages);

	always_comb begin
		if (header.fields.magic == MAGIC_NES && !header.fields.flags6[2])
			kind = KIND_INES;	// Trainers are not supported
		else if (header.fields.magic == MAGIC_FDS || filetype == FT_FDS)
			kind = KIND_FDS;
		else if (filetype == FT_BIOS)
			kind = KIND_BIOS;
		else
			kind = KIND_BAD;
	end

	always_comb begin
		flags_word = '0;
		flags_word[FLG_MAPPER_LSB +: BYTE_W] = mapper_num;
		flags_word[FLG_PRG_LSB +: SIZE_CODE_W] = prg_code;
		flags_word[FLG_CHR_LSB +: SIZE_CODE_W] = chr_code;
		flags_word[FLG_MIRROR] = header.fields.flags6[0] ^ invert_mirroring;
		flags_word[FLG_CHR_RAM] = (chr_pages == '0);	// No CHR ROM means CHR RAM
		flags_word[FLG_FOUR_SCR] = header.fields.flags6[3];
		flags_word[FLG_EXT_LSB +: BYTE_W] = ext_mapper;
	end

endmodule

//--- load_sequencer.sv
///////////////////////////////
// Takes image bytes from the host, captures the header and
// hands every byte that must be stored to the memory write port.
///////////////////////////////
`timescale 1ns/10ps

module load_sequencer (
	input logic clk,
	input logic reset,
	input logic downloading,
	input logic [rom_loader_pkg::BYTE_W-1:0] filetype,
	input logic [rom_loader_pkg::BYTE_W-1:0] in_data,
	input logic in_req,
	input logic wr_busy,
	input rom_loader_pkg::hdr_kind_e kind,
	input logic [rom_loader_pkg::BYTE_W-1:0] prg_pages,
	input logic [rom_loader_pkg::BYTE_W-1:0] chr_pages,
	output logic in_ack,
	output rom_loader_pkg::ines_header_u header,
	output logic wr_valid,
	output logic [rom_loader_pkg::MEM_ADDR_W-1:0] wr_addr,
	output logic [rom_loader_pkg::BYTE_W-1:0] wr_data,
	output logic load_done,
	output logic load_error
);
	import rom_loader_pkg::*;

	localparam int IDX_W = $clog2(HDR_BYTES);

	localparam logic [2:0] S_IDLE = 3'd0;
	localparam logic [2:0] S_HEADER = 3'd1;
	localparam logic [2:0] S_DECIDE = 3'd2;	// Header complete, kind is valid
	localparam logic [2:0] S_PRG = 3'd3;
	localparam logic [2:0] S_CHR = 3'd4;
	localparam logic [2:0] S_STREAM = 3'd5;	// Disk or BIOS body, open ended
	localparam logic [2:0] S_DONE = 3'd6;

	logic [2:0] state;
	logic [IDX_W-1:0] idx;
	logic [MEM_ADDR_W-1:0] addr;
	logic [MEM_ADDR_W-1:0] bytes_left;
	logic dl_q;
	logic dl_rise;
	logic write_state;
	logic discard_state;
	logic offer;
	logic take_write;
	logic take;

	assign dl_rise = downloading & ~dl_q;

	always_comb begin
		write_state = 1'b0;
		discard_state = 1'b0;
		case (state)
			S_HEADER, S_STREAM: write_state = 1'b1;
			S_PRG, S_CHR: write_state = (bytes_left != '0);
			S_DONE: discard_state = 1'b1;	// Trailing bytes are dropped
			default: ;
		endcase
	end

	// A new byte is on offer until it has been acknowledged
	assign offer = in_req & ~in_ack & downloading & ~dl_rise;
	assign take_write = offer & write_state & ~wr_busy;
	assign take = take_write | (offer & discard_state);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_IDLE;
			idx <= '0;
			addr <= '0;
			bytes_left <= '0;
			dl_q <= 1'b0;
			in_ack <= 1'b0;
			wr_valid <= 1'b0;
			load_done <= 1'b0;
			load_error <= 1'b0;
		end else begin
			dl_q <= downloading;
			wr_valid <= take_write;

			if (in_ack && !in_req)
				in_ack <= 1'b0;
			else if (take)
				in_ack <= 1'b1;

			if (take_write) begin
				wr_addr <= addr;
				wr_data <= in_data;
				addr <= addr + 1'b1;
			end

			if (dl_rise) begin
				state <= S_HEADER;
				idx <= '0;
				addr <= (filetype == FT_FDS) ? FDS_BASE : '0;
				load_done <= 1'b0;
				load_error <= 1'b0;
			end else begin
				case (state)
					S_HEADER: if (take_write) begin
						header.bytes[idx] <= in_data;
						idx <= idx + 1'b1;
						if (idx == IDX_W'(HDR_BYTES - 1))
							state <= S_DECIDE;
					end
					S_DECIDE: begin
						case (kind)
							KIND_INES: begin
								state <= S_PRG;
								addr <= PRG_BASE;
								bytes_left <= MEM_ADDR_W'(prg_pages) << PRG_PAGE_LOG2;
							end
							KIND_FDS: begin
								state <= S_STREAM;
								// Raw disk sides get a 16-byte gap where the header would be
								if (header.fields.magic == MAGIC_FDS)
									addr <= FDS_BASE + MEM_ADDR_W'(HDR_BYTES);
								else
									addr <= FDS_BASE + MEM_ADDR_W'(2 * HDR_BYTES);
							end
							KIND_BIOS: begin
								state <= S_STREAM;
								addr <= MEM_ADDR_W'(HDR_BYTES);
							end
							default: begin
								state <= S_DONE;
								load_done <= 1'b1;
								load_error <= 1'b1;
							end
						endcase
					end
					S_PRG: begin
						if (bytes_left == '0) begin
							state <= S_CHR;
							addr <= CHR_BASE;
							bytes_left <= MEM_ADDR_W'(chr_pages) << CHR_PAGE_LOG2;
						end else if (take_write) begin
							bytes_left <= bytes_left - 1'b1;
						end
					end
					S_CHR: begin
						if (bytes_left == '0) begin
							state <= S_DONE;
							load_done <= 1'b1;
						end else if (take_write) begin
							bytes_left <= bytes_left - 1'b1;
						end
					end
					S_STREAM: if (!downloading) begin
						state <= S_DONE;
						load_done <= 1'b1;
						// Fixed disk-system header, gives mapper 20 with CHR RAM
						header.fields.prg_pages <= 8'hFF;
						header.fields.chr_pages <= 8'h00;
						header.fields.flags6 <= 8'h40;
						header.fields.flags7 <= 8'h10;
						header.fields.ext8 <= 8'h00;
						header.fields.tail <= '0;
					end
					default: ;
				endcase
			end
		end
	end

endmodule

//--- mem_write_port.sv
///////////////////////////////
// Holds one pending byte write and runs the four-phase
// req/ack handshake towards the external memory.
///////////////////////////////
`timescale 1ns/10ps

module mem_write_port (
	input logic clk,
	input logic reset,
	input logic wr_valid,
	input logic [rom_loader_pkg::MEM_ADDR_W-1:0] wr_addr,
	input logic [rom_loader_pkg::BYTE_W-1:0] wr_data,
	input logic mem_ack,
	output logic wr_busy,
	output logic [rom_loader_pkg::MEM_ADDR_W-1:0] mem_addr,
	output logic [rom_loader_pkg::BYTE_W-1:0] mem_data,
	output logic mem_req
);

	localparam logic [1:0] P_IDLE = 2'd0;
	localparam logic [1:0] P_REQ = 2'd1;	// mem_req high, waiting for ack
	localparam logic [1:0] P_REL = 2'd2;	// Request dropped, waiting for ack to fall

	logic [1:0] state;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= P_IDLE;
		end else begin
			case (state)
				P_IDLE: if (wr_valid) state <= P_REQ;
				P_REQ: if (mem_ack) state <= P_REL;
				P_REL: if (!mem_ack) state <= P_IDLE;
				default: state <= P_IDLE;
			endcase
		end
	end

	// Address and data stay put for the whole handshake
	always_ff @(posedge clk) begin
		if (wr_valid && state == P_IDLE) begin
			mem_addr <= wr_addr;
			mem_data <= wr_data;
		end
	end

	assign mem_req = (state == P_REQ);
	assign wr_busy = (state != P_IDLE);	// Free only once ack has gone low

endmodule

//--- machine_reset_ctrl.sv
///////////////////////////////
// Holds the console in reset around a download and
// latches the mapper flags when a load completes.
///////////////////////////////
`timescale 1ns/10ps

module machine_reset_ctrl #(
	parameter int RESET_HOLD = 255
) (
	input logic clk,
	input logic reset,
	input logic downloading,
	input logic load_done,
	input logic load_error,
	input logic [rom_loader_pkg::FLAGS_W-1:0] flags_word,
	output logic machine_reset,
	output logic [rom_loader_pkg::FLAGS_W-1:0] mapper_flags
);

	localparam int CNT_W = $clog2(RESET_HOLD + 1);

	logic init_hold;
	logic [CNT_W-1:0] hold_cnt;

	always_ff @(posedge clk) begin
		if (reset) begin
			init_hold <= 1'b1;	// Nothing to run before the first image
			hold_cnt <= '0;
		end else begin
			if (downloading)
				init_hold <= 1'b0;

			if (downloading)
				hold_cnt <= CNT_W'(RESET_HOLD);
			else if (hold_cnt != '0)
				hold_cnt <= hold_cnt - 1'b1;
		end
	end

	assign machine_reset = init_hold | downloading | (hold_cnt != '0) | load_error;

	always_ff @(posedge clk) begin
		if (load_done)
			mapper_flags <= flags_word;
	end

endmodule

//--- rom_loader_top.sv
///////////////////////////////
// ROM loader top level. Host bytes in, memory writes out,
// plus mapper flags and the console reset.
///////////////////////////////
`timescale 1ns/10ps

module rom_loader_top #(
	parameter int RESET_HOLD = 255
) (
	input logic clk,
	input logic reset,
	input logic downloading,
	input logic [rom_loader_pkg::BYTE_W-1:0] filetype,
	input logic invert_mirroring,
	input logic [rom_loader_pkg::BYTE_W-1:0] in_data,
	input logic in_req,
	input logic mem_ack,
	output logic in_ack,
	output logic [rom_loader_pkg::MEM_ADDR_W-1:0] mem_addr,
	output logic [rom_loader_pkg::BYTE_W-1:0] mem_data,
	output logic mem_req,
	output logic [rom_loader_pkg::FLAGS_W-1:0] mapper_flags,
	output logic load_done,
	output logic load_error,
	output logic machine_reset
);
	import rom_loader_pkg::*;

	ines_header_u header;
	hdr_kind_e kind;
	logic [BYTE_W-1:0] prg_pages;
	logic [BYTE_W-1:0] chr_pages;
	logic [FLAGS_W-1:0] flags_word;
	logic wr_valid;
	logic wr_busy;
	logic [MEM_ADDR_W-1:0] wr_addr;
	logic [BYTE_W-1:0] wr_data;

	load_sequencer u_seq (
		.clk(clk),
		.reset(reset),
		.downloading(downloading),
		.filetype(filetype),
		.in_data(in_data),
		.in_req(in_req),
		.wr_busy(wr_busy),
		.kind(kind),
		.prg_pages(prg_pages),
		.chr_pages(chr_pages),
		.in_ack(in_ack),
		.header(header),
		.wr_valid(wr_valid),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.load_done(load_done),
		.load_error(load_error)
	);

	ines_header_decode u_dec (
		.header(header),
		.filetype(filetype),
		.invert_mirroring(invert_mirroring),
		.kind(kind),
		.prg_pages(prg_pages),
		.chr_pages(chr_pages),
		.flags_word(flags_word)
	);

	mem_write_port u_wport (
		.clk(clk),
		.reset(reset),
		.wr_valid(wr_valid),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.mem_ack(mem_ack),
		.wr_busy(wr_busy),
		.mem_addr(mem_addr),
		.mem_data(mem_data),
		.mem_req(mem_req)
	);

	machine_reset_ctrl #(
		.RESET_HOLD(RESET_HOLD)
	) u_rst (
		.clk(clk),
		.reset(reset),
		.downloading(downloading),
		.load_done(load_done),
		.load_error(load_error),
		.flags_word(flags_word),
		.machine_reset(machine_reset),
		.mapper_flags(mapper_flags)
	);

endmodule

//--- rom_loader_tb.sv
///////////////////////////////
// Testbench for the ROM loader. Streams the images listed in
// loader_cases.txt and checks memory writes, flags and reset.
///////////////////////////////
`timescale 1ns/10ps

module rom_loader_tb;
	import rom_loader_pkg::*;

	localparam logic [31:0] SEED = 32'h3255a2c6;
	localparam int FIELDS = 10;	// Columns per case line

	logic clk;
	logic reset;
	logic downloading;
	logic [BYTE_W-1:0] filetype;
	logic invert_mirroring;
	logic [BYTE_W-1:0] in_data;
	logic in_req;
	logic mem_ack;
	logic in_ack;
	logic [MEM_ADDR_W-1:0] mem_addr;
	logic [BYTE_W-1:0] mem_data;
	logic mem_req;
	logic [FLAGS_W-1:0] mapper_flags;
	logic load_done;
	logic load_error;
	logic machine_reset;

	logic [15:0] cases [0:FIELDS*32-1];
	logic [BYTE_W-1:0] exp_mem [logic [MEM_ADDR_W-1:0]];
	logic [BYTE_W-1:0] act_mem [logic [MEM_ADDR_W-1:0]];
	int exp_count = 0;
	int wr_count = 0;
	int cycle = 0;
	int limit_cycles = 0;
	logic [31:0] pay_state;
	logic [31:0] mem_state;

	rom_loader_top #(.RESET_HOLD(255)) dut0 (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) cycle <= cycle + 1;

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [BYTE_W-1:0] rand_byte();
		pay_state = lcg_next(pay_state);
		return pay_state[23:16];
	endfunction

	function automatic int field(input int c, input int f);
		return int'(cases[c * FIELDS + f]);
	endfunction

	// Memory model answers each request after 0 to 3 cycles
	initial begin
		mem_ack = 1'b0;
		mem_state = SEED;
		forever begin
			@(negedge clk);
			if (mem_req && !mem_ack) begin
				mem_state = lcg_next(mem_state);
				repeat (mem_state[17:16]) @(negedge clk);
				act_mem[mem_addr] = mem_data;
				wr_count++;
				mem_ack = 1'b1;
			end else if (!mem_req && mem_ack) begin
				mem_ack = 1'b0;
			end
		end
	end

	task automatic stop_on_error(input string msg);
		$display("Error at %0t ns: %s", $time, msg);
		$display("ERRORS FOUND");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic check_write(input logic [MEM_ADDR_W-1:0] addr, input logic [BYTE_W-1:0] exp);
		if (!act_mem.exists(addr))
			stop_on_error($sformatf("no write seen at address %h", addr));
		else if (act_mem[addr] !== exp)
			stop_on_error($sformatf("address %h holds %h, expected %h", addr, act_mem[addr], exp));
	endtask

	task automatic check_flags(input logic [FLAGS_W-1:0] exp);
		if (mapper_flags !== exp)
			stop_on_error($sformatf("mapper_flags %h, expected %h", mapper_flags, exp));
	endtask

	task automatic check_status(input logic done, input logic err, input logic mrst);
		if ({load_done, load_error, machine_reset} !== {done, err, mrst})
			stop_on_error($sformatf("done/error/reset %b%b%b, expected %b%b%b",
				load_done, load_error, machine_reset, done, err, mrst));
	endtask

	task automatic check_count(input int got, input int exp);
		if (got != exp)
			stop_on_error($sformatf("%0d memory writes seen, expected %0d", got, exp));
	endtask

	// Smallest k with pages <= 2^k but at most 7
	function automatic int size_code(input int pages);
		int k;
		k = 0;
		while (k < 7 && pages > (1 << k))
			k++;
		return k;
	endfunction

	function automatic logic [FLAGS_W-1:0] model_flags(input logic [BYTE_W-1:0] h [16],
		input logic inv);
		logic [FLAGS_W-1:0] f;
		logic nes2;
		logic dirty;
		nes2 = (h[7][3:2] == 2'b10);
		dirty = 1'b0;
		for (int i = 8; i < 16; i++)
			dirty = dirty | (h[i] != 8'h00);
		f = '0;
		f[7:4] = (dirty && !nes2) ? 4'h0 : h[7][7:4];
		f[3:0] = h[6][7:4];
		f[10:8] = 3'(size_code(int'(h[4])));
		f[13:11] = 3'(size_code(int'(h[5])));
		f[14] = h[6][0] ^ inv;
		f[15] = (h[5] == 8'h00);
		f[16] = h[6][3];
		f[24:17] = nes2 ? h[8] : 8'h00;
		return f;
	endfunction

	// Column 2 picks the magic and column 5 holds flags6 with the trainer bit
	function automatic hdr_kind_e expect_kind(input int c);
		int flags6;
		flags6 = field(c, 5);
		if (field(c, 2) == 0 && !flags6[2])
			return KIND_INES;
		if (field(c, 2) == 1 || field(c, 0) == int'(FT_FDS))
			return KIND_FDS;
		if (field(c, 0) == int'(FT_BIOS))
			return KIND_BIOS;
		return KIND_BAD;
	endfunction

	// Four-phase byte transfer that also counts the write it should cause
	task automatic send_byte(input logic [BYTE_W-1:0] data, input logic write,
		input logic [MEM_ADDR_W-1:0] addr);
		in_data = data;
		in_req = 1'b1;
		@(negedge clk);
		while (!in_ack) @(negedge clk);
		if (write) begin
			check_count(wr_count, exp_count);	// Earlier writes must be done first
			exp_mem[addr] = data;
			exp_count++;
		end
		in_req = 1'b0;
		@(negedge clk);
		while (in_ack) @(negedge clk);
	endtask

	initial begin
		logic [BYTE_W-1:0] hdr [16];
		logic [MEM_ADDR_W-1:0] base;
		hdr_kind_e kind;
		int total;
		int drop_cycle;
		reset = 1'b1;
		downloading = 1'b0;
		filetype = '0;
		invert_mirroring = 1'b0;
		in_data = '0;
		in_req = 1'b0;
		pay_state = SEED;
		foreach (cases[i]) cases[i] = 16'hFFFF;
		$readmemh("loader_cases.txt", cases);
		total = 0;
		for (int c = 0; field(c, 0) != 'hFFFF; c++) begin
			total += 16 + field(c, 9) + 400;
			if (expect_kind(c) == KIND_INES)
				total += field(c, 3) * 16384 + field(c, 4) * 8192;
		end
		limit_cycles = total * 16 + 2000;
		repeat (4) @(negedge clk);
		reset = 1'b0;
		repeat (4) @(negedge clk);
		check_status(1'b0, 1'b0, 1'b1);	// No image loaded yet

		for (int c = 0; field(c, 0) != 'hFFFF; c++) begin
			kind = expect_kind(c);
			hdr[0] = (field(c, 2) == 0) ? "N" : (field(c, 2) == 1) ? "F" : "R";
			hdr[1] = (field(c, 2) == 0) ? "E" : (field(c, 2) == 1) ? "D" : "O";
			hdr[2] = (field(c, 2) < 2) ? "S" : "M";
			hdr[3] = 8'h1A;
			for (int i = 4; i < 9; i++)
				hdr[i] = BYTE_W'(field(c, i - 1));
			for (int i = 9; i < 15; i++)
				hdr[i] = 8'h00;
			hdr[15] = BYTE_W'(field(c, 8));
			filetype = BYTE_W'(field(c, 0));
			invert_mirroring = 1'(field(c, 1));
			downloading = 1'b1;
			@(negedge clk);
			base = (filetype == FT_FDS) ? FDS_BASE : '0;
			for (int i = 0; i < 16; i++)
				send_byte(hdr[i], 1'b1, base + MEM_ADDR_W'(i));
			if (kind == KIND_INES) begin
				for (int i = 0; i < field(c, 3) * 16384; i++)
					send_byte(rand_byte(), 1'b1, PRG_BASE + MEM_ADDR_W'(i));
				for (int i = 0; i < field(c, 4) * 8192; i++)
					send_byte(rand_byte(), 1'b1, CHR_BASE + MEM_ADDR_W'(i));
			end else if (kind != KIND_BAD) begin
				base = (kind == KIND_BIOS) ? 22'd16
					: FDS_BASE + MEM_ADDR_W'((field(c, 2) == 1) ? 16 : 32);
				for (int i = 0; i < field(c, 9); i++)
					send_byte(rand_byte(), 1'b1, base + MEM_ADDR_W'(i));
				check_status(1'b0, 1'b0, 1'b1);	// Open ended until the host stops
				downloading = 1'b0;
				drop_cycle = cycle;
			end
			while (!load_done) @(negedge clk);
			check_status(1'b1, kind == KIND_BAD, 1'b1);
			@(negedge clk);
			if (kind == KIND_FDS || kind == KIND_BIOS)
				check_flags({16'h0, 1'b1, invert_mirroring, 3'd0, 3'd7, 8'd20});
			else
				check_flags(model_flags(hdr, invert_mirroring));
			if (kind == KIND_INES || kind == KIND_BAD) begin
				for (int i = 0; i < field(c, 9); i++)
					send_byte(rand_byte(), 1'b0, '0);	// Trailer bytes are dropped by the loader
				downloading = 1'b0;
				drop_cycle = cycle;
			end
			while (mem_req || mem_ack) @(negedge clk);
			foreach (exp_mem[a]) check_write(a, exp_mem[a]);
			foreach (act_mem[a]) begin
				if (!exp_mem.exists(a))
					stop_on_error($sformatf("unexpected write at address %h", a));
			end
			check_count(wr_count, exp_count);
			exp_mem.delete();
			act_mem.delete();
			exp_count = 0;
			wr_count = 0;
			while (cycle < drop_cycle + 254) @(negedge clk);
			check_status(1'b1, kind == KIND_BAD, 1'b1);
			@(negedge clk);
			check_status(1'b1, kind == KIND_BAD, kind == KIND_BAD);	// Hold ends after 255
		end
		$display("NO ERRORS");
		$finish;
	end

	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		$display("ERRORS FOUND");
		$fatal(1, "Timeout, the loader did not finish within %0d cycles", limit_cycles);
	end

endmodule

//--- loader_cases.txt
// filetype invert magic(0 NES, 1 FDS, 2 other) prg chr flags6 flags7 ext8 dirty trailer
// All values hex, one image per line
0 0 0 01 01 11 20 00 00 0005
0 1 0 01 00 48 00 00 00 0003
0 0 0 01 01 31 50 00 44 0000
0 0 0 01 03 20 18 05 07 0002
0 1 1 00 00 00 00 00 00 0028
3 0 2 04 02 00 00 00 00 001e
3 1 1 02 01 00 00 00 00 0014
2 0 2 00 00 00 00 00 00 0032
0 0 2 c8 64 01 00 00 00 0004
0 1 0 01 01 04 00 00 00 0002

//--- flist.f
rom_loader_pkg.sv
ines_header_decode.sv
load_sequencer.sv
mem_write_port.sv
machine_reset_ctrl.sv
rom_loader_top.sv
rom_loader_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile the ROM loader testbench with Verilator and run it from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module rom_loader_tb -f flist.f -o rom_loader_sim &&
./obj_dir/rom_loader_sim || { echo "simulation failed"; exit 1; }
